//--- src/uart_pkg.sv
//**************************************************************************
// serial framing constants for the 8N1 transmitter
// ascii codes used by the hex test pattern
//**************************************************************************

package uart_pkg;

	// frame layout: start, data lsb first, stop
	localparam int data_bits  = 8;
	localparam int frame_bits = 10;
	localparam int idx_width  = 4; // holds 0 .. frame_bits-1

	// index of the stop bit within a frame
	localparam logic [idx_width-1:0] stop_index = idx_width'(frame_bits - 1);

	// bit period counter width, clocks per bit
	localparam int div_width = 16;

	// pattern characters
	localparam logic [data_bits-1:0] char_cr   = 8'h0d;
	localparam logic [data_bits-1:0] char_lf   = 8'h0a;
	localparam logic [data_bits-1:0] char_zero = 8'h30; // '0'
	localparam logic [data_bits-1:0] char_a    = 8'h61; // lower case 'a'

endpackage

//--- src/regmap_pkg.sv
//**************************************************************************
// APB register map of the pattern transmitter
// addresses, field positions, limits and reset values
//**************************************************************************

package regmap_pkg;

	localparam int addr_width = 8;
	localparam int data_width = 32;

	// word addresses
	localparam logic [addr_width-1:0] addr_ctrl = 8'h00;
	localparam logic [addr_width-1:0] addr_div  = 8'h04;
	localparam logic [addr_width-1:0] addr_len  = 8'h08;
	localparam logic [addr_width-1:0] addr_stat = 8'h0c;

	// ctrl and stat bit positions
	localparam int ctrl_enable_bit = 0;
	localparam int stat_busy_bit   = 0;
	localparam int stat_count_lsb  = 8;
	localparam int cnt_width       = 16; // sent count, wraps

	// divisor field, clocks per bit
	localparam logic [uart_pkg::div_width-1:0] div_min   = 16'd4;
	localparam logic [uart_pkg::div_width-1:0] div_reset = 16'd16;

	// line length field, digits per line
	localparam int len_width = 7;
	localparam logic [len_width-1:0] len_min   = 7'd1;
	localparam logic [len_width-1:0] len_max   = 7'd64;
	localparam logic [len_width-1:0] len_reset = 7'd64;

endpackage

//--- src/apb_regs.sv
//**************************************************************************
// APB3 slave with ctrl, div, len and stat registers
// clamps divisor and line length, counts sent characters
//**************************************************************************

`timescale 1ns/100ps

module apb_regs (
	input  logic                                  clock,
	input  logic                                  arst_n,
	input  logic [regmap_pkg::addr_width-1:0]     paddr,
	input  logic                                  psel,
	input  logic                                  penable,
	input  logic                                  pwrite,
	input  logic [regmap_pkg::data_width-1:0]     pwdata,
	input  logic                                  busy,
	input  logic                                  sent,
	output logic [regmap_pkg::data_width-1:0]     prdata,
	output logic                                  pready,
	output logic                                  pslverr,
	output logic                                  enable,
	output logic [uart_pkg::div_width-1:0]        divisor,
	output logic [regmap_pkg::len_width-1:0]      line_len
);
	logic access;
	logic wr;
	logic sel_ctrl;
	logic sel_div;
	logic sel_len;
	logic sel_stat;
	logic hit;
	logic [uart_pkg::div_width-1:0]    div_in;
	logic [regmap_pkg::len_width-1:0]  len_in;
	logic [regmap_pkg::cnt_width-1:0]  sent_count;

	assign sel_ctrl = (paddr == regmap_pkg::addr_ctrl);
	assign sel_div  = (paddr == regmap_pkg::addr_div);
	assign sel_len  = (paddr == regmap_pkg::addr_len);
	assign sel_stat = (paddr == regmap_pkg::addr_stat);
	assign hit      = sel_ctrl | sel_div | sel_len | sel_stat;

	assign access  = psel & penable; // second cycle of a transfer
	assign wr      = access & pwrite;
	assign pready  = 1'b1;           // no wait states
	assign pslverr = access & ~hit;

	// written values clamped before they are stored
	assign div_in = (pwdata[uart_pkg::div_width-1:0] < regmap_pkg::div_min) ?
		regmap_pkg::div_min : pwdata[uart_pkg::div_width-1:0];

	always_comb begin
		if (pwdata == '0)
			len_in = regmap_pkg::len_min;
		else if (pwdata > regmap_pkg::len_max)
			len_in = regmap_pkg::len_max;
		else
			len_in = pwdata[regmap_pkg::len_width-1:0];
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			enable     <= 1'b0;
			divisor    <= regmap_pkg::div_reset;
			line_len   <= regmap_pkg::len_reset;
			sent_count <= '0;
		end else begin
			if (wr && sel_ctrl)
				enable <= pwdata[regmap_pkg::ctrl_enable_bit];
			if (wr && sel_div)
				divisor <= div_in;
			if (wr && sel_len)
				line_len <= len_in;
			if (sent)
				sent_count <= sent_count + 1'b1; // wraps at 16 bits
		end
	end

	// read mux, stat is live
	always_comb begin
		prdata = '0;
		if (sel_ctrl) begin
			prdata[regmap_pkg::ctrl_enable_bit] = enable;
		end else if (sel_div) begin
			prdata[uart_pkg::div_width-1:0] = divisor;
		end else if (sel_len) begin
			prdata[regmap_pkg::len_width-1:0] = line_len;
		end else if (sel_stat) begin
			prdata[regmap_pkg::stat_busy_bit] = busy;
			prdata[regmap_pkg::stat_count_lsb +: regmap_pkg::cnt_width] = sent_count;
		end
	end

endmodule

//--- src/pattern_gen.sv
//**************************************************************************
// test pattern sequencer: hex digits 0..f per line, then CR and LF
// issues one load per character while the serializer is idle
//**************************************************************************

`timescale 1ns/100ps

module pattern_gen #(
	parameter int len_w = 7
) (
	input  logic                            clock,
	input  logic                            arst_n,
	input  logic                            enable,
	input  logic [len_w-1:0]                line_len,
	input  logic                            busy,
	output logic                            load,
	output logic [uart_pkg::data_bits-1:0]  tx_data
);
	logic [len_w-1:0]  digit;      // digit index within the line
	logic [len_w-1:0]  digit_next;
	logic              in_cr;
	logic              in_lf;
	logic              armed;      // one clock ahead of load
	logic              send_cr;
	logic [3:0]        nibble;
	logic [uart_pkg::data_bits-1:0] hex_char;

	// a line shortened under us ends with CR at the next digit
	assign send_cr    = in_cr | (!in_lf && (digit >= line_len));
	assign digit_next = digit + 1'b1;
	assign nibble     = digit[3:0];

	assign hex_char = (nibble < 4'd10) ?
		uart_pkg::char_zero + {{(uart_pkg::data_bits-4){1'b0}}, nibble} :
		uart_pkg::char_a + {{(uart_pkg::data_bits-4){1'b0}}, nibble - 4'd10};

	always_comb begin
		if (send_cr)
			tx_data = uart_pkg::char_cr;
		else if (in_lf)
			tx_data = uart_pkg::char_lf;
		else
			tx_data = hex_char;
	end

	// two stage request: idle seen, then load
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			armed <= 1'b0;
			load  <= 1'b0;
		end else begin
			armed <= enable && !busy && !armed && !load;
			load  <= armed && enable; // dropped if enable went low
		end
	end

	// position only moves once the character is taken
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			digit <= '0;
			in_cr <= 1'b0;
			in_lf <= 1'b0;
		end else if (load) begin
			if (send_cr) begin
				in_cr <= 1'b0;
				in_lf <= 1'b1;
			end else if (in_lf) begin
				in_lf <= 1'b0;
				digit <= '0; // start of next line
			end else if (digit_next >= line_len) begin
				in_cr <= 1'b1;
			end else begin
				digit <= digit_next;
			end
		end
	end

endmodule

//--- src/uart_tx.sv
//**************************************************************************
// 8N1 serializer with load/busy handshake
// bit period set by a divisor sampled at load
//**************************************************************************

`timescale 1ns/100ps

module uart_tx (
	input  logic                            clock,
	input  logic                            arst_n,
	input  logic                            load,
	input  logic [uart_pkg::data_bits-1:0]  tx_data,
	input  logic [uart_pkg::div_width-1:0]  divisor,
	output logic                            tx,
	output logic                            busy,
	output logic                            sent
);
	logic [uart_pkg::div_width-1:0]  period;  // clocks per bit for this frame
	logic [uart_pkg::div_width-1:0]  count;   // clocks left in current bit
	logic [uart_pkg::data_bits:0]    shift;   // data lsb first, stop on top
	logic [uart_pkg::idx_width-1:0]  bit_idx; // 0 start .. stop_index stop
	logic                            bit_done;
	logic                            start;

	assign bit_done = (count == '0);
	assign start    = load & ~busy;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			tx      <= 1'b1; // line idles high
			busy    <= 1'b0;
			sent    <= 1'b0;
			count   <= '0;
			bit_idx <= '0;
		end else begin
			sent <= 1'b0;
			if (!busy) begin
				if (load) begin
					busy    <= 1'b1;
					tx      <= 1'b0; // start bit
					count   <= divisor - 1'b1;
					bit_idx <= '0;
				end
			end else if (bit_done) begin
				if (bit_idx == uart_pkg::stop_index) begin
					busy <= 1'b0; // end of stop bit, tx stays high
					sent <= 1'b1;
				end else begin
					tx      <= shift[0];
					count   <= period - 1'b1;
					bit_idx <= bit_idx + 1'b1;
				end
			end else begin
				count <= count - 1'b1;
			end
		end
	end

	// frame payload
	always_ff @(posedge clock) begin
		if (start) begin
			shift  <= {1'b1, tx_data};
			period <= divisor;
		end else if (busy && bit_done) begin
			shift <= {1'b1, shift[uart_pkg::data_bits:1]};
		end
	end

endmodule

//--- src/uart_pattern_top.sv
//**************************************************************************
// UART test pattern transmitter top level
// register block, pattern sequencer and serializer
//**************************************************************************

`timescale 1ns/100ps

module uart_pattern_top (
	input  logic                               clock,
	input  logic                               arst_n,
	input  logic [regmap_pkg::addr_width-1:0]  paddr,
	input  logic                               psel,
	input  logic                               penable,
	input  logic                               pwrite,
	input  logic [regmap_pkg::data_width-1:0]  pwdata,
	output logic [regmap_pkg::data_width-1:0]  prdata,
	output logic                               pready,
	output logic                               pslverr,
	output logic                               tx
);
	logic                                enable;
	logic [uart_pkg::div_width-1:0]      divisor;
	logic [regmap_pkg::len_width-1:0]    line_len;
	logic                                load;
	logic [uart_pkg::data_bits-1:0]      tx_data;
	logic                                busy;
	logic                                sent; // one pulse per finished frame

	apb_regs regs (
		.clock    (clock),
		.arst_n   (arst_n),
		.paddr    (paddr),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.pwdata   (pwdata),
		.busy     (busy),
		.sent     (sent),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.enable   (enable),
		.divisor  (divisor),
		.line_len (line_len)
	);

	pattern_gen #(
		.len_w (regmap_pkg::len_width)
	) seq (
		.clock    (clock),
		.arst_n   (arst_n),
		.enable   (enable),
		.line_len (line_len),
		.busy     (busy),
		.load     (load),
		.tx_data  (tx_data)
	);

	uart_tx serializer (
		.clock    (clock),
		.arst_n   (arst_n),
		.load     (load),
		.tx_data  (tx_data),
		.divisor  (divisor),
		.tx       (tx),
		.busy     (busy),
		.sent     (sent)
	);

endmodule

//--- dv/tb_uart_pattern.sv
//**************************************************************************
// directed testbench for the UART test pattern transmitter
// APB tasks, serial frame decoder, pattern model and checks
//**************************************************************************

`timescale 1ns/100ps

module tb_uart_pattern;
	localparam int max_div      = 20;  // largest divisor streamed
	localparam int total_frames = 160; // all tests together, idle checks included
	localparam int cycle_limit  = 2 * total_frames * uart_pkg::frame_bits * max_div;

	logic        clock, arst_n, psel, penable, pwrite, pready, pslverr, tx;
	logic [7:0]  paddr;
	logic [31:0] pwdata, prdata;
	logic [15:0] lfsr = 16'd45;
	int cycles    = 0;
	int cur_div   = 16;
	int cur_len   = 64;
	int exp_digit = 0;
	int exp_phase = 0; // 0 digit, 1 CR, 2 LF
	int total_rx  = 0;

	uart_pattern_top UUT (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit)
			stop_with_failure($sformatf("timeout: run went past %0d clock cycles", cycle_limit));
	end

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_equal(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else stop_with_failure($sformatf("mismatch at %0d ns: %s is %h, expected %h",
			$time, what, got, exp));
	endtask

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output int v);
		v = 0;
		repeat (n) begin
			lfsr = lfsr_step(lfsr);
			v = (v << 1) | lfsr[0];
		end
	endtask

	// setup cycle, access cycle, inputs move 10 ns after the edge
	task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] data,
		input logic exp_err, output logic [31:0] rdata);
		@(posedge clock);
		#10;
		paddr   = addr;
		pwrite  = wr;
		pwdata  = data;
		psel    = 1'b1;
		penable = 1'b0;
		@(posedge clock);
		#10;
		penable = 1'b1;
		@(negedge clock); // mid access cycle
		rdata = prdata;
		check_equal("pready", pready, 1);
		check_equal($sformatf("pslverr at address %h", addr), pslverr, exp_err);
		@(posedge clock);
		#10;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
		input logic exp_err);
		logic [31:0] unused;
		apb_access(addr, 1'b1, data, exp_err, unused);
	endtask

	task automatic apb_read(input logic [7:0] addr, input logic exp_err, output logic [31:0] data);
		apb_access(addr, 1'b0, '0, exp_err, data);
	endtask

	task automatic read_check(input logic [7:0] addr, input logic [31:0] exp, input string what);
		logic [31:0] d;
		apb_read(addr, 1'b0, d);
		check_equal(what, d, exp);
	endtask

	// polls for the start bit, then samples mid bit with the known divisor
	task automatic receive_char(output logic [7:0] c, output bit got, output int waited,
		input int limit);
		got    = 0;
		waited = 0;
		c      = '0;
		@(negedge clock);
		while (tx === 1'b1 && waited < limit) begin
			waited++;
			@(negedge clock);
		end
		if (tx === 1'b0) begin
			got = 1;
			repeat (cur_div / 2) @(negedge clock);
			check_equal("start bit", tx, 0);
			for (int i = 0; i < uart_pkg::data_bits; i++) begin
				repeat (cur_div) @(negedge clock);
				c[i] = tx; // lsb first
			end
			repeat (cur_div) @(negedge clock);
			check_equal("stop bit", tx, 1);
		end
	endtask

	// pattern rule: len digits, CR, LF; a shortened line ends at the next digit
	task automatic next_expected(output logic [7:0] c);
		int n;
		n = exp_digit % 16;
		if (exp_phase == 1 || (exp_phase == 0 && exp_digit >= cur_len)) begin
			c = uart_pkg::char_cr;
			exp_phase = 2;
		end else if (exp_phase == 2) begin
			c = uart_pkg::char_lf;
			exp_phase = 0;
			exp_digit = 0;
		end else begin
			c = (n < 10) ? 8'(uart_pkg::char_zero + n) : 8'(uart_pkg::char_a + n - 10);
			if (exp_digit + 1 >= cur_len)
				exp_phase = 1;
			else
				exp_digit++;
		end
	endtask

	task automatic take_char(input logic [7:0] c);
		logic [7:0] e;
		next_expected(e);
		check_equal("received character", c, e);
		total_rx++;
	endtask

	task automatic expect_line(input int n);
		logic [7:0] c;
		bit         got;
		int         w;
		repeat (n) begin
			receive_char(c, got, w, uart_pkg::frame_bits * cur_div + 8);
			assert (got) else stop_with_failure("no character arrived while the stream was enabled");
			take_char(c);
		end
	endtask

	// clear enable, then take whatever frames still come out
	task automatic stop_stream();
		logic [7:0] c;
		bit         got;
		int         w;
		apb_write(regmap_pkg::addr_ctrl, 0, 1'b0);
		got = 1;
		while (got) begin
			receive_char(c, got, w, uart_pkg::frame_bits * cur_div + 8);
			if (got)
				take_char(c);
		end
	endtask

	task automatic expect_idle(input int n);
		repeat (n) begin
			@(negedge clock);
			assert (tx === 1'b1)
			else stop_with_failure("start bit seen while the stream was disabled");
		end
	endtask

	task automatic set_div(input int d);
		apb_write(regmap_pkg::addr_div, d, 1'b0);
		cur_div = d;
	endtask

	task automatic set_len(input int l);
		apb_write(regmap_pkg::addr_len, l, 1'b0);
		cur_len = l;
	endtask

	initial begin
		logic [31:0] d;
		logic [7:0]  c;
		bit          got;
		int          w;
		int          v;
		arst_n  = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		repeat (3) @(posedge clock);
		#10 arst_n = 1'b1;

		// reset values, line stays idle
		read_check(regmap_pkg::addr_ctrl, 0, "ctrl after reset");
		read_check(regmap_pkg::addr_div, 16, "div after reset");
		read_check(regmap_pkg::addr_len, 64, "len after reset");
		read_check(regmap_pkg::addr_stat, 0, "stat after reset");
		expect_idle(3 * uart_pkg::frame_bits * 16);

		// register access and clamping
		apb_write(regmap_pkg::addr_ctrl, 0, 1'b0);
		read_check(regmap_pkg::addr_ctrl, 0, "ctrl");
		apb_write(regmap_pkg::addr_div, 100, 1'b0);
		read_check(regmap_pkg::addr_div, 100, "div");
		apb_write(regmap_pkg::addr_len, 37, 1'b0);
		read_check(regmap_pkg::addr_len, 37, "len");
		apb_write(regmap_pkg::addr_div, 2, 1'b0);
		read_check(regmap_pkg::addr_div, 4, "div clamped up");
		apb_write(regmap_pkg::addr_len, 0, 1'b0);
		read_check(regmap_pkg::addr_len, 1, "len clamped up");
		apb_write(regmap_pkg::addr_len, 100, 1'b0);
		read_check(regmap_pkg::addr_len, 64, "len clamped down");
		apb_write(8'h10, 32'h0000_0021, 1'b1); // unmapped, data differs from every field
		apb_read(8'h10, 1'b1, d);
		read_check(regmap_pkg::addr_div, 4, "div after unmapped write");
		read_check(regmap_pkg::addr_len, 64, "len after unmapped write");
		read_check(regmap_pkg::addr_ctrl, 0, "ctrl after unmapped write");
		apb_write(regmap_pkg::addr_stat, 32'hffff_ffff, 1'b0);
		read_check(regmap_pkg::addr_stat, 0, "stat after write");
		read_check(regmap_pkg::addr_ctrl, 0, "ctrl after stat write");

		// pattern with fixed, then random line lengths
		set_div(8);
		set_len(5);
		apb_write(regmap_pkg::addr_ctrl, 1, 1'b0);
		expect_line(14);
		stop_stream();
		set_len(18); // passes 9 to a and f to 0
		apb_write(regmap_pkg::addr_ctrl, 1, 1'b0);
		expect_line(40);
		stop_stream();
		take_bits(5, v);
		set_len(1 + v % 20);
		apb_write(regmap_pkg::addr_ctrl, 1, 1'b0);
		expect_line(2 * (cur_len + 2));
		stop_stream();

		// random divisor, start bit three clocks after enable
		take_bits(4, v);
		set_div(4 + v);
		apb_write(regmap_pkg::addr_ctrl, 1, 1'b0);
		receive_char(c, got, w, uart_pkg::frame_bits * cur_div + 8);
		assert (got) else stop_with_failure("no start bit after the enable write");
		assert (w == 3)
		else stop_with_failure($sformatf(
			"mismatch at %0d ns: start bit %0d clocks after enable, expected 3", $time, w));
		take_char(c);
		expect_line(13);
		stop_stream();

		// disable mid frame, then resume
		apb_write(regmap_pkg::addr_ctrl, 1, 1'b0);
		expect_line(3);
		fork
			receive_char(c, got, w, uart_pkg::frame_bits * cur_div + 8);
			begin
				@(negedge clock);
				while (tx === 1'b1)
					@(negedge clock);
				repeat (3 * cur_div) @(negedge clock); // well inside the frame
				read_check(regmap_pkg::addr_ctrl, 1, "ctrl while streaming");
				read_check(regmap_pkg::addr_stat, ((total_rx % 65536) << 8) | 1,
					"stat while busy");
				apb_write(regmap_pkg::addr_ctrl, 0, 1'b0);
			end
		join
		assert (got) else stop_with_failure("frame in flight at disable did not arrive");
		take_char(c);
		expect_idle(3 * uart_pkg::frame_bits * cur_div);
		apb_write(regmap_pkg::addr_ctrl, 1, 1'b0);
		expect_line(8);
		stop_stream();

		// sent count against the decoder
		read_check(regmap_pkg::addr_stat, (total_rx % 65536) << 8, "stat count");

		$display("Test completed successfully");
		$finish;
	end

endmodule

//--- uart_pattern.f
src/uart_pkg.sv
src/regmap_pkg.sv
src/apb_regs.sv
src/pattern_gen.sv
src/uart_tx.sv
src/uart_pattern_top.sv
dv/tb_uart_pattern.sv
